//--- alu.sv
`default_nettype none

module alu (
    input  riscv_isa_pkg::word_t   a,
    input  riscv_isa_pkg::word_t   b,
    input  core_ctrl_pkg::alu_op_t op,
    output riscv_isa_pkg::word_t   result,
    output logic                   zero
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;   // Keeps sign bit
            default:  result = '0;
        endcase
    end

    // Used by branches only
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    // ALU operation codes
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b0001,
        alu_and  = 4'b0010,
        alu_or   = 4'b0011,
        alu_xor  = 4'b0100,
        alu_sltu = 4'b1001,
        alu_slt  = 4'b1010,
        alu_sll  = 4'b1101,
        alu_srl  = 4'b1110,
        alu_sra  = 4'b1111
    } alu_op_t;

    // Data memory geometry
    localparam int dmem_words     = 256;
    localparam int dmem_addr_bits = $clog2(dmem_words);

    // Fetch starts here after reset
    localparam logic [31:0] reset_pc = 32'h0000_0000;

endpackage

`default_nettype wire

//--- data_memory.sv
`default_nettype none

module data_memory (
    input  wire                                     clk,
    input  wire                                     write_en,
    input  wire [core_ctrl_pkg::dmem_addr_bits-1:0] word_addr,
    input  riscv_isa_pkg::word_t                    write_data,
    output riscv_isa_pkg::word_t                    read_data
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t mem [dmem_words];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[word_addr] <= write_data;
        end
    end

    // Asynchronous read path for LW
    assign read_data = mem[word_addr];

endmodule

`default_nettype wire

//--- decoder.sv
`default_nettype none

module decoder (
    input  riscv_isa_pkg::word_t   instr,
    output logic                   reg_write,
    output logic                   mem_write,
    output logic                   mem_to_reg,
    output logic                   alu_src_imm,
    output logic                   branch,
    output logic                   branch_when_zero,
    output core_ctrl_pkg::alu_op_t alu_op,
    output riscv_isa_pkg::word_t   imm
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [opc_bits-1:0] opcode;
    logic [f3_bits-1:0]  funct3;
    logic                alt;
    word_t               imm_i;
    word_t               imm_s;
    word_t               imm_b;
    alu_op_t             arith_op;      // Op for R and I forms

    assign opcode = instr[opc_lsb +: opc_bits];
    assign funct3 = instr[f3_lsb +: f3_bits];
    assign alt    = instr[f7_alt_bit];

    // Sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (funct3)
            // In ADDI bit 30 belongs to the immediate
            f3_add_sub: arith_op = (alt && opcode == opc_rtype) ? alu_sub : alu_add;
            f3_sll:     arith_op = alu_sll;
            f3_slt:     arith_op = alu_slt;
            f3_sltu:    arith_op = alu_sltu;
            f3_xor:     arith_op = alu_xor;
            f3_srl_sra: arith_op = alt ? alu_sra : alu_srl;
            f3_or:      arith_op = alu_or;
            f3_and:     arith_op = alu_and;
            default:    arith_op = alu_add;
        endcase
    end

    always_comb begin
        reg_write        = 1'b0;
        mem_write        = 1'b0;
        mem_to_reg       = 1'b0;
        alu_src_imm      = 1'b0;
        branch           = 1'b0;
        branch_when_zero = 1'b0;
        alu_op           = alu_add;
        imm              = '0;
        case (opcode)
            opc_rtype: begin
                reg_write = 1'b1;
                alu_op    = arith_op;
            end
            opc_itype: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = arith_op;
                imm         = imm_i;
            end
            opc_load: begin
                reg_write   = 1'b1;
                mem_to_reg  = 1'b1;
                alu_src_imm = 1'b1;     // Address is rs1 + offset
                imm         = imm_i;
            end
            opc_store: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = imm_s;
            end
            opc_branch: begin
                imm    = imm_b;
                branch = 1'b1;
                case (funct3)
                    f3_beq:  {alu_op, branch_when_zero} = {alu_sub, 1'b1};
                    f3_bne:  {alu_op, branch_when_zero} = {alu_sub, 1'b0};
                    f3_blt:  {alu_op, branch_when_zero} = {alu_slt, 1'b0};
                    f3_bge:  {alu_op, branch_when_zero} = {alu_slt, 1'b1};
                    f3_bltu: {alu_op, branch_when_zero} = {alu_sltu, 1'b0};
                    f3_bgeu: {alu_op, branch_when_zero} = {alu_sltu, 1'b1};
                    default: branch = 1'b0;     // Reserved funct3, no branch
                endcase
            end
            default: ;      // Unknown opcode acts as a no-op
        endcase
    end

endmodule

`default_nettype wire

//--- list.f
riscv_isa_pkg.sv
core_ctrl_pkg.sv
decoder.sv
register_file.sv
alu.sv
pc_unit.sv
data_memory.sv
riscv_core.sv
tb_riscv_core.sv

//--- pc_unit.sv
`default_nettype none

module pc_unit (
    input  wire                  clk,
    input  wire                  rst,
    input  riscv_isa_pkg::word_t imm,
    input  wire                  branch,
    input  wire                  branch_when_zero,
    input  wire                  alu_zero,
    output riscv_isa_pkg::word_t pc
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t pc_plus4;
    word_t pc_target;
    logic  taken;

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;        // B immediate already has bit 0 clear

    // Flag polarity carries the funct3 decision
    assign taken = branch && (alu_zero == branch_when_zero);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else begin
            pc <= taken ? pc_target : pc_plus4;
        end
    end

endmodule

`default_nettype wire

//--- register_file.sv
`default_nettype none

module register_file (
    input  wire                       clk,
    input  riscv_isa_pkg::reg_addr_t  rs1_addr,
    input  riscv_isa_pkg::reg_addr_t  rs2_addr,
    input  riscv_isa_pkg::reg_addr_t  rd_addr,
    input  riscv_isa_pkg::word_t      rd_data,
    input  wire                       write_en,
    output riscv_isa_pkg::word_t      rs1_data,
    output riscv_isa_pkg::word_t      rs2_data
);
    import riscv_isa_pkg::*;

    localparam int num_regs = 2 ** reg_addr_bits;

    word_t regs [num_regs];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (write_en && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Combinational reads, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- riscv_core.sv
`default_nettype none

module riscv_core (
    input  wire                       clk,
    input  wire                       rst,
    input  riscv_isa_pkg::word_t      instr,
    output riscv_isa_pkg::word_t      pc,
    output logic                      wb_en,
    output riscv_isa_pkg::reg_addr_t  wb_addr,
    output riscv_isa_pkg::word_t      wb_data
);
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic    reg_write;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src_imm;
    logic    branch;
    logic    branch_when_zero;
    alu_op_t alu_op;
    word_t   imm;

    word_t   rs1_data;
    word_t   rs2_data;
    word_t   alu_b;
    word_t   alu_result;
    logic    alu_zero;
    word_t   mem_rdata;

    decoder u_decoder (
        .instr            (instr),
        .reg_write        (reg_write),
        .mem_write        (mem_write),
        .mem_to_reg       (mem_to_reg),
        .alu_src_imm      (alu_src_imm),
        .branch           (branch),
        .branch_when_zero (branch_when_zero),
        .alu_op           (alu_op),
        .imm              (imm)
    );

    register_file u_regs (
        .clk      (clk),
        .rs1_addr (instr[rs1_lsb +: reg_addr_bits]),
        .rs2_addr (instr[rs2_lsb +: reg_addr_bits]),
        .rd_addr  (wb_addr),
        .rd_data  (wb_data),
        .write_en (wb_en),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_b = alu_src_imm ? imm : rs2_data;

    alu u_alu (
        .a      (rs1_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    pc_unit u_pc (
        .clk              (clk),
        .rst              (rst),
        .imm              (imm),
        .branch           (branch),
        .branch_when_zero (branch_when_zero),
        .alu_zero         (alu_zero),
        .pc               (pc)
    );

    data_memory u_dmem (
        .clk        (clk),
        .write_en   (mem_write),
        .word_addr  (alu_result[2 +: dmem_addr_bits]),    // Byte address to word index
        .write_data (rs2_data),
        .read_data  (mem_rdata)
    );

    // Writeback, held off during reset
    assign wb_en   = reg_write && !rst;
    assign wb_addr = instr[rd_lsb +: reg_addr_bits];
    assign wb_data = mem_to_reg ? mem_rdata : alu_result;

endmodule

`default_nettype wire

//--- riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    localparam int xlen          = 32;
    localparam int reg_addr_bits = 5;

    typedef logic [xlen-1:0]          word_t;
    typedef logic [reg_addr_bits-1:0] reg_addr_t;

    // Field positions in the instruction word
    localparam int opc_lsb    = 0;
    localparam int opc_bits   = 7;
    localparam int rd_lsb     = 7;
    localparam int f3_lsb     = 12;
    localparam int f3_bits    = 3;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int f7_alt_bit = 30;     // Selects SUB and SRA

    localparam logic [opc_bits-1:0] opc_rtype  = 7'b0110011;
    localparam logic [opc_bits-1:0] opc_itype  = 7'b0010011;
    localparam logic [opc_bits-1:0] opc_load   = 7'b0000011;
    localparam logic [opc_bits-1:0] opc_store  = 7'b0100011;
    localparam logic [opc_bits-1:0] opc_branch = 7'b1100011;

    // ALU funct3, shared by register and immediate forms
    localparam logic [f3_bits-1:0] f3_add_sub = 3'b000;
    localparam logic [f3_bits-1:0] f3_sll     = 3'b001;
    localparam logic [f3_bits-1:0] f3_slt     = 3'b010;
    localparam logic [f3_bits-1:0] f3_sltu    = 3'b011;
    localparam logic [f3_bits-1:0] f3_xor     = 3'b100;
    localparam logic [f3_bits-1:0] f3_srl_sra = 3'b101;
    localparam logic [f3_bits-1:0] f3_or      = 3'b110;
    localparam logic [f3_bits-1:0] f3_and     = 3'b111;

    // Branch funct3
    localparam logic [f3_bits-1:0] f3_beq  = 3'b000;
    localparam logic [f3_bits-1:0] f3_bne  = 3'b001;
    localparam logic [f3_bits-1:0] f3_blt  = 3'b100;
    localparam logic [f3_bits-1:0] f3_bge  = 3'b101;
    localparam logic [f3_bits-1:0] f3_bltu = 3'b110;
    localparam logic [f3_bits-1:0] f3_bgeu = 3'b111;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_riscv_core -f list.f -o tb_sim \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi
./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi
cat sim.log
if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0

//--- tb_riscv_core.sv
`default_nettype none

module tb_riscv_core;
    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam int trace_len    = 36;
    localparam int max_cycles   = reset_cycles + trace_len + 20;

    logic      clk;
    logic      rst;
    word_t     instr;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    // Execution trace with one row per retired instruction
    word_t     exp_pc   [trace_len];
    word_t     prog     [trace_len];
    logic      exp_en   [trace_len];
    reg_addr_t exp_addr [trace_len];
    word_t     exp_data [trace_len];
    int        group_of [trace_len];
    string     group_name [5] = '{"immediate", "register", "load_store", "branch", "x0"};

    int rows       = 0;
    int checks     = 0;
    int errors     = 0;
    int grp_checks = 0;
    int grp_errors = 0;
    int cycles     = 0;

    riscv_core uut (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: trace did not finish within %0d cycles", max_cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic word_t enc_i(logic [6:0] opc, int imm, int rs1, logic [2:0] f3, int rd);
        enc_i = {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t enc_r(int alt, int rs2, int rs1, logic [2:0] f3, int rd);
        enc_r = {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_rtype};
    endfunction

    function automatic word_t enc_s(int imm, int rs2, int rs1);
        enc_s = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};   // SW only
    endfunction

    function automatic word_t enc_b(int imm, int rs2, int rs1, logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opc_branch};
    endfunction

    task automatic add_step(int grp, int pc_val, word_t word, int en, int rd, word_t data);
        group_of[rows] = grp;
        exp_pc[rows]   = pc_val;
        prog[rows]     = word;
        exp_en[rows]   = (en != 0);
        exp_addr[rows] = rd[4:0];
        exp_data[rows] = data;
        rows++;
    endtask

    task automatic check_word(string name, word_t actual, word_t expected);
        checks++;
        assert (actual === expected) else begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_group(string name);
        $display("Test %s: %0d checks, %0d errors", name, checks - grp_checks,
                 errors - grp_errors);
        grp_checks = checks;
        grp_errors = errors;
    endtask

    task automatic load_trace();
        add_step(0, 0, enc_i(opc_itype, -5, 0, f3_add_sub, 1), 1, 1, 32'hffff_fffb);
        add_step(0, 4, enc_i(opc_itype, 12, 0, f3_add_sub, 2), 1, 2, 32'h0000_000c);
        add_step(0, 8, enc_i(opc_itype, -3, 1, f3_slt, 3), 1, 3, 32'h1);     // -5 < -3
        add_step(0, 12, enc_i(opc_itype, 5, 1, f3_sltu, 4), 1, 4, 32'h0);    // x1 huge unsigned
        add_step(0, 16, enc_i(opc_itype, 'hff, 2, f3_xor, 5), 1, 5, 32'hf3);
        add_step(0, 20, enc_i(opc_itype, 'h501, 2, f3_or, 6), 1, 6, 32'h50d);
        add_step(0, 24, enc_i(opc_itype, 'hf0, 1, f3_and, 7), 1, 7, 32'hf0);
        add_step(0, 28, enc_i(opc_itype, 4, 2, f3_sll, 8), 1, 8, 32'hc0);
        add_step(0, 32, enc_i(opc_itype, 28, 1, f3_srl_sra, 9), 1, 9, 32'hf);
        add_step(0, 36, enc_i(opc_itype, 'h401, 1, f3_srl_sra, 10), 1, 10, 32'hffff_fffd); // SRAI
        add_step(1, 40, enc_r(0, 2, 1, f3_add_sub, 11), 1, 11, 32'h7);
        add_step(1, 44, enc_r(1, 2, 1, f3_add_sub, 12), 1, 12, 32'hffff_ffef);
        add_step(1, 48, enc_r(0, 3, 2, f3_sll, 13), 1, 13, 32'h18);
        add_step(1, 52, enc_r(0, 2, 1, f3_slt, 14), 1, 14, 32'h1);
        add_step(1, 56, enc_r(0, 2, 1, f3_sltu, 15), 1, 15, 32'h0);
        add_step(1, 60, enc_r(0, 2, 1, f3_xor, 16), 1, 16, 32'hffff_fff7);
        add_step(1, 64, enc_r(0, 3, 1, f3_srl_sra, 17), 1, 17, 32'h7fff_fffd);
        add_step(1, 68, enc_r(1, 3, 1, f3_srl_sra, 18), 1, 18, 32'hffff_fffd);
        add_step(1, 72, enc_r(0, 5, 2, f3_or, 19), 1, 19, 32'hff);
        add_step(1, 76, enc_r(0, 6, 1, f3_and, 20), 1, 20, 32'h509);
        add_step(2, 80, enc_s(8, 1, 2), 0, 0, 32'h0);                        // Word 5
        add_step(2, 84, enc_i(opc_load, 8, 2, 3'b010, 21), 1, 21, 32'hffff_fffb);
        // Taken branches skip one word
        add_step(3, 88, enc_b(8, 2, 2, f3_beq), 0, 0, 32'h0);
        add_step(3, 96, enc_b(8, 2, 1, f3_beq), 0, 0, 32'h0);
        add_step(3, 100, enc_b(8, 2, 1, f3_bne), 0, 0, 32'h0);
        add_step(3, 108, enc_b(8, 2, 2, f3_bne), 0, 0, 32'h0);
        add_step(3, 112, enc_b(8, 2, 1, f3_blt), 0, 0, 32'h0);
        add_step(3, 120, enc_b(8, 1, 2, f3_blt), 0, 0, 32'h0);
        add_step(3, 124, enc_b(8, 1, 2, f3_bge), 0, 0, 32'h0);
        add_step(3, 132, enc_b(8, 2, 1, f3_bge), 0, 0, 32'h0);
        add_step(3, 136, enc_b(8, 1, 2, f3_bltu), 0, 0, 32'h0);
        add_step(3, 144, enc_b(8, 2, 1, f3_bltu), 0, 0, 32'h0);
        add_step(3, 148, enc_b(8, 2, 1, f3_bgeu), 0, 0, 32'h0);
        add_step(3, 156, enc_b(8, 1, 2, f3_bgeu), 0, 0, 32'h0);
        add_step(4, 160, enc_i(opc_itype, 99, 0, f3_add_sub, 0), 1, 0, 32'd99);
        add_step(4, 164, enc_r(0, 2, 0, f3_add_sub, 22), 1, 22, 32'hc);      // x0 still zero
    endtask

    initial begin
        rst   = 1'b1;
        instr = enc_i(opc_itype, 1, 0, f3_add_sub, 5);     // Must not retire under reset
        load_trace();
        repeat (reset_cycles) begin
            @(negedge clk);
            check_word("pc", pc, reset_pc);
            check_word("wb_en", {31'b0, wb_en}, 32'd0);
        end
        report_group("reset");
        rst = 1'b0;
        for (int i = 0; i < trace_len; i++) begin
            check_word("pc", pc, exp_pc[i]);
            instr = prog[i];
            #(clk_period / 4);      // Let decode settle
            check_word("wb_en", {31'b0, wb_en}, {31'b0, exp_en[i]});
            if (exp_en[i]) begin
                check_word("wb_addr", {27'b0, wb_addr}, {27'b0, exp_addr[i]});
                check_word("wb_data", wb_data, exp_data[i]);
            end
            if (i == trace_len - 1)
                report_group(group_name[group_of[i]]);
            else if (group_of[i + 1] != group_of[i])
                report_group(group_name[group_of[i]]);
            @(negedge clk);
        end
        check_word("pc", pc, 32'd168);      // Falls through after the last row
        report_group("final_pc");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
